// ==== design/lsu_params.svh ====
`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

// lanes per warp
`define LSU_NUM_THREADS 4

// in-flight load slots and the tag that indexes them
`define LSU_QUEUE_SIZE 8
`define LSU_TAG_BITS 3

// warp id and destination register widths
`define LSU_NW_BITS 2
`define LSU_NR_BITS 5

`endif

// ==== design/lsu_pkg.sv ====
`default_nettype none

`include "lsu_params.svh"

package lsu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [`LSU_NUM_THREADS-1:0] tmask_t;
    typedef logic [`LSU_NW_BITS-1:0] wid_t;
    typedef logic [`LSU_NR_BITS-1:0] rd_t;
    typedef logic [`LSU_TAG_BITS-1:0] tag_t;
    typedef logic [1:0] byte_off_t;

    // loads first, stores after
    typedef enum logic [2:0] {
        LB,
        LH,
        LW,
        LBU,
        LHU,
        SB,
        SH,
        SW
    } lsu_op_t;

    // what a load needs back when its data returns
    typedef struct packed {
        wid_t wid;
        word_t pc;
        tmask_t tmask;
        rd_t rd;
        lsu_op_t op;
        byte_off_t [`LSU_NUM_THREADS-1:0] offset;
    } lsu_meta_t;

    function automatic logic op_is_load(lsu_op_t op);
        return (op == LB) || (op == LH) || (op == LW) || (op == LBU) || (op == LHU);
    endfunction

endpackage

`default_nettype wire

// ==== design/lsu_addr_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "lsu_params.svh"

module lsu_addr_stage (
    input  wire                                         clk,
    input  wire                                         reset,
    input  wire                                         req_valid_in,
    output logic                                        req_ready_out,
    input  wire lsu_pkg::wid_t                          wid,
    input  wire lsu_pkg::tmask_t                        tmask,
    input  wire lsu_pkg::word_t                         pc,
    input  wire lsu_pkg::lsu_op_t                       op,
    input  wire lsu_pkg::word_t [`LSU_NUM_THREADS-1:0]  base_addr,
    input  wire lsu_pkg::word_t                         offset,
    input  wire lsu_pkg::word_t [`LSU_NUM_THREADS-1:0]  store_data,
    input  wire lsu_pkg::rd_t                           rd,
    output logic                                        out_valid,
    input  wire                                         out_ready,
    output lsu_pkg::wid_t                               out_wid,
    output lsu_pkg::tmask_t                             out_tmask,
    output lsu_pkg::word_t                              out_pc,
    output lsu_pkg::lsu_op_t                            out_op,
    output lsu_pkg::word_t [`LSU_NUM_THREADS-1:0]       out_addr,
    output lsu_pkg::word_t [`LSU_NUM_THREADS-1:0]       out_data,
    output lsu_pkg::rd_t                                out_rd
);
    import lsu_pkg::*;

    word_t [`LSU_NUM_THREADS-1:0] full_addr;
    logic enable;

    always_comb begin
        for (int i = 0; i < `LSU_NUM_THREADS; i++) begin
            full_addr[i] = base_addr[i] + offset;
        end
    end

    // register empty or draining this cycle
    assign enable = !out_valid || out_ready;
    assign req_ready_out = enable;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (enable) begin
            out_valid <= req_valid_in;
        end
    end

    always_ff @(posedge clk) begin
        if (enable && req_valid_in) begin
            out_wid   <= wid;
            out_tmask <= tmask;
            out_pc    <= pc;
            out_op    <= op;
            out_addr  <= full_addr;
            out_data  <= store_data;
            out_rd    <= rd;
        end
    end

endmodule

`default_nettype wire

// ==== design/lsu_req_issue.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "lsu_params.svh"

module lsu_req_issue (
    input  wire                                         clk,
    input  wire                                         reset,
    input  wire                                         in_valid,
    output logic                                        in_ready,
    input  wire lsu_pkg::wid_t                          in_wid,
    input  wire lsu_pkg::tmask_t                        in_tmask,
    input  wire lsu_pkg::word_t                         in_pc,
    input  wire lsu_pkg::lsu_op_t                       in_op,
    input  wire lsu_pkg::word_t [`LSU_NUM_THREADS-1:0]  in_addr,
    input  wire lsu_pkg::word_t [`LSU_NUM_THREADS-1:0]  in_data,
    input  wire lsu_pkg::rd_t                           in_rd,
    output logic [`LSU_NUM_THREADS-1:0]                 dcache_req_valid,
    input  wire [`LSU_NUM_THREADS-1:0]                  dcache_req_ready,
    output logic                                        dcache_req_rw,
    output logic [`LSU_NUM_THREADS-1:0][29:0]           dcache_req_addr,
    output logic [`LSU_NUM_THREADS-1:0][3:0]            dcache_req_byteen,
    output lsu_pkg::word_t [`LSU_NUM_THREADS-1:0]       dcache_req_data,
    output lsu_pkg::tag_t [`LSU_NUM_THREADS-1:0]        dcache_req_tag,
    output logic                                        alloc,
    output lsu_pkg::lsu_meta_t                          alloc_meta,
    input  wire lsu_pkg::tag_t                          alloc_tag,
    input  wire                                         full,
    output logic                                        st_commit_valid,
    input  wire                                         st_commit_ready,
    output lsu_pkg::wid_t                               st_commit_wid,
    output lsu_pkg::tmask_t                             st_commit_tmask,
    output lsu_pkg::word_t                              st_commit_pc
);
    import lsu_pkg::*;

    tmask_t sent_mask;
    tmask_t pending;
    tmask_t fire;
    logic is_load;
    logic is_start;
    logic dep_ready;
    logic lanes_done;
    tag_t tag_hold;
    tag_t req_tag;

    assign is_load  = op_is_load(in_op);
    assign is_start = (sent_mask == '0);
    assign pending  = in_tmask & ~sent_mask;

    // loads need a slot up front, stores need the commit port
    assign dep_ready  = is_load ? !(full && is_start) : st_commit_ready;
    assign lanes_done = &(~pending | dcache_req_ready);
    assign in_ready   = dep_ready && lanes_done;

    assign dcache_req_valid = {`LSU_NUM_THREADS{in_valid && dep_ready}} & pending;
    assign fire = dcache_req_valid & dcache_req_ready;

    assign alloc = in_valid && is_load && is_start && (|fire);
    assign req_tag = is_start ? alloc_tag : tag_hold;

    always_ff @(posedge clk) begin
        if (reset) begin
            sent_mask <= '0;
        end else if (in_valid && in_ready) begin
            sent_mask <= '0;
        end else begin
            sent_mask <= sent_mask | fire;
        end
    end

    // slot stays with the instruction across partial accepts
    always_ff @(posedge clk) begin
        if (alloc) begin
            tag_hold <= alloc_tag;
        end
    end

    always_comb begin
        alloc_meta.wid   = in_wid;
        alloc_meta.pc    = in_pc;
        alloc_meta.tmask = in_tmask;
        alloc_meta.rd    = in_rd;
        alloc_meta.op    = in_op;
        for (int i = 0; i < `LSU_NUM_THREADS; i++) begin
            alloc_meta.offset[i] = in_addr[i][1:0];
        end
    end

    assign dcache_req_rw = !is_load;

    always_comb begin
        for (int i = 0; i < `LSU_NUM_THREADS; i++) begin
            dcache_req_addr[i] = in_addr[i][31:2];
            dcache_req_tag[i]  = req_tag;
            dcache_req_data[i] = in_data[i] << {in_addr[i][1:0], 3'b000};
            case (in_op)
                SB: dcache_req_byteen[i] = 4'b0001 << in_addr[i][1:0];
                SH: dcache_req_byteen[i] = 4'b0011 << {in_addr[i][1], 1'b0};
                default: dcache_req_byteen[i] = 4'b1111;
            endcase
        end
    end

    // fires together with the last store lane
    assign st_commit_valid = in_valid && !is_load && in_ready;
    assign st_commit_wid   = in_wid;
    assign st_commit_tmask = in_tmask;
    assign st_commit_pc    = in_pc;

endmodule

`default_nettype wire

// ==== design/lsu_tag_buffer.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "lsu_params.svh"

module lsu_tag_buffer (
    input  wire                         clk,
    input  wire                         reset,
    input  wire                         alloc,
    input  wire lsu_pkg::lsu_meta_t     alloc_meta,
    output lsu_pkg::tag_t               alloc_tag,
    output logic                        full,
    input  wire                         rsp_valid,
    input  wire                         rsp_ready,
    input  wire lsu_pkg::tmask_t        rsp_tmask,
    input  wire lsu_pkg::tag_t          rsp_tag,
    output logic                        fire_out,
    output lsu_pkg::lsu_meta_t          meta_out,
    output logic                        last_out
);
    import lsu_pkg::*;

    logic [`LSU_QUEUE_SIZE-1:0] used;
    lsu_meta_t meta_mem [`LSU_QUEUE_SIZE];
    tmask_t rem_mask [`LSU_QUEUE_SIZE];
    tmask_t rem_next;

    assign full = &used;

    // lowest free slot
    always_comb begin
        alloc_tag = '0;
        for (int i = `LSU_QUEUE_SIZE - 1; i >= 0; i--) begin
            if (!used[i]) begin
                alloc_tag = tag_t'(i);
            end
        end
    end

    assign fire_out = rsp_valid && rsp_ready;
    assign meta_out = meta_mem[rsp_tag];
    assign rem_next = rem_mask[rsp_tag] & ~rsp_tmask;
    assign last_out = (rem_next == '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            used <= '0;
        end else begin
            if (alloc) begin
                used[alloc_tag] <= 1'b1;
            end
            if (fire_out && last_out) begin
                used[rsp_tag] <= 1'b0;
            end
        end
    end

    // alloc and response never target the same slot
    always_ff @(posedge clk) begin
        if (alloc) begin
            meta_mem[alloc_tag] <= alloc_meta;
            rem_mask[alloc_tag] <= alloc_meta.tmask;
        end
        if (fire_out) begin
            rem_mask[rsp_tag] <= rem_next;
        end
    end

endmodule

`default_nettype wire

// ==== design/lsu_rsp_format.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "lsu_params.svh"

module lsu_rsp_format (
    input  wire                                         clk,
    input  wire                                         reset,
    input  wire                                         fire,
    input  wire lsu_pkg::lsu_meta_t                     meta,
    input  wire                                         last,
    input  wire lsu_pkg::tmask_t                        rsp_tmask,
    input  wire lsu_pkg::word_t [`LSU_NUM_THREADS-1:0]  rsp_data,
    output logic                                        rsp_ready,
    output logic                                        ld_commit_valid,
    input  wire                                         ld_commit_ready,
    output lsu_pkg::wid_t                               ld_commit_wid,
    output lsu_pkg::tmask_t                             ld_commit_tmask,
    output lsu_pkg::word_t                              ld_commit_pc,
    output lsu_pkg::rd_t                                ld_commit_rd,
    output lsu_pkg::word_t [`LSU_NUM_THREADS-1:0]       ld_commit_data,
    output logic                                        ld_commit_eop
);
    import lsu_pkg::*;

    word_t [`LSU_NUM_THREADS-1:0] fmt_data;
    logic stall;

    always_comb begin
        logic [15:0] half;
        logic [7:0] byte_val;
        for (int i = 0; i < `LSU_NUM_THREADS; i++) begin
            half     = meta.offset[i][1] ? rsp_data[i][31:16] : rsp_data[i][15:0];
            byte_val = meta.offset[i][0] ? half[15:8] : half[7:0];
            case (meta.op)
                LB:  fmt_data[i] = {{24{byte_val[7]}}, byte_val};
                LH:  fmt_data[i] = {{16{half[15]}}, half};
                LBU: fmt_data[i] = {24'd0, byte_val};
                LHU: fmt_data[i] = {16'd0, half};
                default: fmt_data[i] = rsp_data[i];
            endcase
        end
    end

    // hold the output until commit takes it
    assign stall = ld_commit_valid && !ld_commit_ready;
    assign rsp_ready = !stall;

    always_ff @(posedge clk) begin
        if (reset) begin
            ld_commit_valid <= 1'b0;
        end else if (!stall) begin
            ld_commit_valid <= fire;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall && fire) begin
            ld_commit_wid   <= meta.wid;
            ld_commit_tmask <= rsp_tmask;
            ld_commit_pc    <= meta.pc;
            ld_commit_rd    <= meta.rd;
            ld_commit_data  <= fmt_data;
            ld_commit_eop   <= last;
        end
    end

endmodule

`default_nettype wire

// ==== design/lsu_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "lsu_params.svh"

module lsu_unit (
    input  wire                                         clk,
    input  wire                                         reset,
    input  wire                                         lsu_req_valid,
    output logic                                        lsu_req_ready,
    input  wire lsu_pkg::wid_t                          lsu_req_wid,
    input  wire lsu_pkg::tmask_t                        lsu_req_tmask,
    input  wire lsu_pkg::word_t                         lsu_req_pc,
    input  wire lsu_pkg::lsu_op_t                       lsu_req_op,
    input  wire lsu_pkg::word_t [`LSU_NUM_THREADS-1:0]  lsu_req_base_addr,
    input  wire lsu_pkg::word_t                         lsu_req_offset,
    input  wire lsu_pkg::word_t [`LSU_NUM_THREADS-1:0]  lsu_req_store_data,
    input  wire lsu_pkg::rd_t                           lsu_req_rd,
    output logic [`LSU_NUM_THREADS-1:0]                 dcache_req_valid,
    input  wire [`LSU_NUM_THREADS-1:0]                  dcache_req_ready,
    output logic                                        dcache_req_rw,
    output logic [`LSU_NUM_THREADS-1:0][29:0]           dcache_req_addr,
    output logic [`LSU_NUM_THREADS-1:0][3:0]            dcache_req_byteen,
    output lsu_pkg::word_t [`LSU_NUM_THREADS-1:0]       dcache_req_data,
    output lsu_pkg::tag_t [`LSU_NUM_THREADS-1:0]        dcache_req_tag,
    input  wire                                         dcache_rsp_valid,
    output logic                                        dcache_rsp_ready,
    input  wire lsu_pkg::tmask_t                        dcache_rsp_tmask,
    input  wire lsu_pkg::word_t [`LSU_NUM_THREADS-1:0]  dcache_rsp_data,
    input  wire lsu_pkg::tag_t                          dcache_rsp_tag,
    output logic                                        st_commit_valid,
    input  wire                                         st_commit_ready,
    output lsu_pkg::wid_t                               st_commit_wid,
    output lsu_pkg::tmask_t                             st_commit_tmask,
    output lsu_pkg::word_t                              st_commit_pc,
    output logic                                        ld_commit_valid,
    input  wire                                         ld_commit_ready,
    output lsu_pkg::wid_t                               ld_commit_wid,
    output lsu_pkg::tmask_t                             ld_commit_tmask,
    output lsu_pkg::word_t                              ld_commit_pc,
    output lsu_pkg::rd_t                                ld_commit_rd,
    output lsu_pkg::word_t [`LSU_NUM_THREADS-1:0]       ld_commit_data,
    output logic                                        ld_commit_eop
);
    import lsu_pkg::*;

    logic req_valid;
    logic req_ready;
    wid_t req_wid;
    tmask_t req_tmask;
    word_t req_pc;
    lsu_op_t req_op;
    word_t [`LSU_NUM_THREADS-1:0] req_addr;
    word_t [`LSU_NUM_THREADS-1:0] req_data;
    rd_t req_rd;

    logic alloc;
    lsu_meta_t alloc_meta;
    tag_t alloc_tag;
    logic full;

    logic rsp_fire;
    lsu_meta_t rsp_meta;
    logic rsp_last;

    lsu_addr_stage addr_stage (
        .clk           (clk),
        .reset         (reset),
        .req_valid_in  (lsu_req_valid),
        .req_ready_out (lsu_req_ready),
        .wid           (lsu_req_wid),
        .tmask         (lsu_req_tmask),
        .pc            (lsu_req_pc),
        .op            (lsu_req_op),
        .base_addr     (lsu_req_base_addr),
        .offset        (lsu_req_offset),
        .store_data    (lsu_req_store_data),
        .rd            (lsu_req_rd),
        .out_valid     (req_valid),
        .out_ready     (req_ready),
        .out_wid       (req_wid),
        .out_tmask     (req_tmask),
        .out_pc        (req_pc),
        .out_op        (req_op),
        .out_addr      (req_addr),
        .out_data      (req_data),
        .out_rd        (req_rd)
    );

    lsu_req_issue req_issue (
        .clk               (clk),
        .reset             (reset),
        .in_valid          (req_valid),
        .in_ready          (req_ready),
        .in_wid            (req_wid),
        .in_tmask          (req_tmask),
        .in_pc             (req_pc),
        .in_op             (req_op),
        .in_addr           (req_addr),
        .in_data           (req_data),
        .in_rd             (req_rd),
        .dcache_req_valid  (dcache_req_valid),
        .dcache_req_ready  (dcache_req_ready),
        .dcache_req_rw     (dcache_req_rw),
        .dcache_req_addr   (dcache_req_addr),
        .dcache_req_byteen (dcache_req_byteen),
        .dcache_req_data   (dcache_req_data),
        .dcache_req_tag    (dcache_req_tag),
        .alloc             (alloc),
        .alloc_meta        (alloc_meta),
        .alloc_tag         (alloc_tag),
        .full              (full),
        .st_commit_valid   (st_commit_valid),
        .st_commit_ready   (st_commit_ready),
        .st_commit_wid     (st_commit_wid),
        .st_commit_tmask   (st_commit_tmask),
        .st_commit_pc      (st_commit_pc)
    );

    lsu_tag_buffer tag_buffer (
        .clk        (clk),
        .reset      (reset),
        .alloc      (alloc),
        .alloc_meta (alloc_meta),
        .alloc_tag  (alloc_tag),
        .full       (full),
        .rsp_valid  (dcache_rsp_valid),
        .rsp_ready  (dcache_rsp_ready),
        .rsp_tmask  (dcache_rsp_tmask),
        .rsp_tag    (dcache_rsp_tag),
        .fire_out   (rsp_fire),
        .meta_out   (rsp_meta),
        .last_out   (rsp_last)
    );

    lsu_rsp_format rsp_format (
        .clk             (clk),
        .reset           (reset),
        .fire            (rsp_fire),
        .meta            (rsp_meta),
        .last            (rsp_last),
        .rsp_tmask       (dcache_rsp_tmask),
        .rsp_data        (dcache_rsp_data),
        .rsp_ready       (dcache_rsp_ready),
        .ld_commit_valid (ld_commit_valid),
        .ld_commit_ready (ld_commit_ready),
        .ld_commit_wid   (ld_commit_wid),
        .ld_commit_tmask (ld_commit_tmask),
        .ld_commit_pc    (ld_commit_pc),
        .ld_commit_rd    (ld_commit_rd),
        .ld_commit_data  (ld_commit_data),
        .ld_commit_eop   (ld_commit_eop)
    );

endmodule

`default_nettype wire

// ==== tests/dcache_model.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "lsu_params.svh"

module dcache_model (
    input  wire                                         clk,
    input  wire                                         reset,
    input  wire [`LSU_NUM_THREADS-1:0]                  dcache_req_valid,
    output logic [`LSU_NUM_THREADS-1:0]                 dcache_req_ready,
    input  wire                                         dcache_req_rw,
    input  wire [`LSU_NUM_THREADS-1:0][29:0]            dcache_req_addr,
    input  wire [`LSU_NUM_THREADS-1:0][3:0]             dcache_req_byteen,
    input  wire lsu_pkg::word_t [`LSU_NUM_THREADS-1:0]  dcache_req_data,
    input  wire lsu_pkg::tag_t [`LSU_NUM_THREADS-1:0]   dcache_req_tag,
    output logic                                        dcache_rsp_valid,
    input  wire                                         dcache_rsp_ready,
    output lsu_pkg::tmask_t                             dcache_rsp_tmask,
    output lsu_pkg::word_t [`LSU_NUM_THREADS-1:0]       dcache_rsp_data,
    output lsu_pkg::tag_t                               dcache_rsp_tag
);
    import lsu_pkg::*;

    localparam int NT = `LSU_NUM_THREADS;
    localparam int NQ = `LSU_QUEUE_SIZE;

    word_t mem [256];
    // lanes accepted but not answered yet, per tag
    tmask_t pend [NQ];
    word_t [NT-1:0] pend_data [NQ];
    int delay [NQ];

    initial begin
        int t;
        logic taken;
        tmask_t sub;
        for (int i = 0; i < 256; i++) begin
            mem[i] = 32'h6b43a9b5 ^ (32'(i) * 32'h01000193);
        end
        for (int q = 0; q < NQ; q++) begin
            pend[q] = '0;
            delay[q] = 0;
        end
        dcache_req_ready = '0;
        dcache_rsp_valid = 1'b0;
        dcache_rsp_tmask = '0;
        dcache_rsp_data = '0;
        dcache_rsp_tag = '0;
        forever begin
            @(posedge clk);
            taken = dcache_rsp_valid && dcache_rsp_ready;
            for (int i = 0; i < NT; i++) begin
                if (!reset && dcache_req_valid[i] && dcache_req_ready[i]) begin
                    if (dcache_req_rw) begin
                        for (int b = 0; b < 4; b++) begin
                            if (dcache_req_byteen[i][b]) begin
                                mem[dcache_req_addr[i][7:0]][8*b +: 8] = dcache_req_data[i][8*b +: 8];
                            end
                        end
                    end else begin
                        t = int'(dcache_req_tag[i]);
                        if (pend[t] == '0) begin
                            delay[t] = int'($urandom % 8);
                        end
                        pend[t][i] = 1'b1;
                        pend_data[t][i] = mem[dcache_req_addr[i][7:0]];
                    end
                end
            end

            @(negedge clk);
            for (int i = 0; i < NT; i++) begin
                dcache_req_ready[i] = ($urandom % 4) != 0;
            end
            if (reset || taken) begin
                dcache_rsp_valid = 1'b0;
            end
            for (int q = 0; q < NQ; q++) begin
                if (delay[q] > 0) begin
                    delay[q] = delay[q] - 1;
                end
            end
            // random starting tag so answers to different loads interleave
            t = int'($urandom % NQ);
            for (int k = 0; k < NQ; k++) begin
                if (!reset && !dcache_rsp_valid && pend[t] != '0 && delay[t] == 0) begin
                    sub = pend[t] & tmask_t'($urandom);
                    if (sub == '0) begin
                        sub = pend[t];
                    end
                    pend[t] = pend[t] & ~sub;
                    delay[t] = int'($urandom % 8);
                    dcache_rsp_valid = 1'b1;
                    dcache_rsp_tag = tag_t'(t);
                    dcache_rsp_tmask = sub;
                    for (int i = 0; i < NT; i++) begin
                        dcache_rsp_data[i] = sub[i] ? pend_data[t][i] : $urandom;
                    end
                end
                t = (t + 1) % NQ;
            end
        end
    end

endmodule

`default_nettype wire

// ==== tests/lsu_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "lsu_params.svh"

module lsu_tb;
    import lsu_pkg::*;

    localparam int NT = `LSU_NUM_THREADS;
    localparam int NUM_TESTS = 58;
    localparam int MEM_WORDS = 256;

    typedef struct {
        string name;
        wid_t wid;
        word_t pc;
        tmask_t tmask;
        rd_t rd;
        word_t [NT-1:0] data;
        tmask_t got;
    } exp_t;

    logic clk;
    logic reset;
    logic lsu_req_valid;
    logic lsu_req_ready;
    wid_t lsu_req_wid;
    tmask_t lsu_req_tmask;
    word_t lsu_req_pc;
    lsu_op_t lsu_req_op;
    word_t [NT-1:0] lsu_req_base_addr;
    word_t lsu_req_offset;
    word_t [NT-1:0] lsu_req_store_data;
    rd_t lsu_req_rd;
    logic [NT-1:0] dcache_req_valid;
    logic [NT-1:0] dcache_req_ready;
    logic dcache_req_rw;
    logic [NT-1:0][29:0] dcache_req_addr;
    logic [NT-1:0][3:0] dcache_req_byteen;
    word_t [NT-1:0] dcache_req_data;
    tag_t [NT-1:0] dcache_req_tag;
    logic dcache_rsp_valid;
    logic dcache_rsp_ready;
    tmask_t dcache_rsp_tmask;
    word_t [NT-1:0] dcache_rsp_data;
    tag_t dcache_rsp_tag;
    logic st_commit_valid;
    logic st_commit_ready;
    wid_t st_commit_wid;
    tmask_t st_commit_tmask;
    word_t st_commit_pc;
    logic ld_commit_valid;
    logic ld_commit_ready;
    wid_t ld_commit_wid;
    tmask_t ld_commit_tmask;
    word_t ld_commit_pc;
    rd_t ld_commit_rd;
    word_t [NT-1:0] ld_commit_data;
    logic ld_commit_eop;

    word_t ref_mem [MEM_WORDS];
    exp_t st_q [$];
    exp_t ld_exp [word_t];
    word_t next_pc;
    string test_name;
    logic rand_bp = 1'b0;
    int errors = 0;
    int n_st = 0;
    int n_ld = 0;

    lsu_unit DUT (.*);
    dcache_model cache (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic word_t eff_addr(word_t base, word_t offset);
        return base + offset;
    endfunction

    // memory word after a store of the given size at byte offset off
    function automatic word_t store_merge(word_t old, lsu_op_t op, logic [1:0] off, word_t data);
        word_t w;
        w = old;
        case (op)
            SB: w[{off, 3'b000} +: 8] = data[7:0];
            SH: w[{off[1], 4'b0000} +: 16] = data[15:0];
            default: w = data;
        endcase
        return w;
    endfunction

    function automatic word_t load_format(lsu_op_t op, logic [1:0] off, word_t w);
        logic [7:0] b;
        logic [15:0] h;
        b = w[{off, 3'b000} +: 8];
        h = w[{off[1], 4'b0000} +: 16];
        case (op)
            LB: return {{24{b[7]}}, b};
            LH: return {{16{h[15]}}, h};
            LBU: return {24'd0, b};
            LHU: return {16'd0, h};
            default: return w;
        endcase
    endfunction

    task automatic check_value(string name, string what, word_t expected, word_t actual);
        if (expected !== actual) begin
            errors++;
            $display("ERR %s %s expected %h actual %h", name, what, expected, actual);
        end
    endtask

    // called at a falling edge, returns at the falling edge after acceptance
    task automatic send(lsu_op_t op, tmask_t tmask, int region, logic [1:0] off);
        exp_t e;
        word_t addr;
        e.name = test_name;
        e.wid = wid_t'($urandom);
        e.pc = next_pc;
        e.tmask = tmask;
        e.rd = rd_t'($urandom);
        e.data = '0;
        e.got = '0;
        next_pc = next_pc + 4;
        lsu_req_offset = $urandom;
        for (int i = 0; i < NT; i++) begin
            addr = 32'(((region * NT + i) % MEM_WORDS) * 4) + 32'(off);
            lsu_req_base_addr[i] = addr - lsu_req_offset;
            lsu_req_store_data[i] = $urandom;
            addr = eff_addr(lsu_req_base_addr[i], lsu_req_offset);
            if (tmask[i] && (op inside {SB, SH, SW})) begin
                ref_mem[addr[9:2]] = store_merge(ref_mem[addr[9:2]], op, addr[1:0],
                                                 lsu_req_store_data[i]);
            end else if (tmask[i]) begin
                e.data[i] = load_format(op, addr[1:0], ref_mem[addr[9:2]]);
            end
        end
        if (op inside {SB, SH, SW}) begin
            st_q.push_back(e);
        end else begin
            ld_exp[e.pc] = e;
        end
        lsu_req_valid = 1'b1;
        lsu_req_op = op;
        lsu_req_tmask = tmask;
        lsu_req_wid = e.wid;
        lsu_req_pc = e.pc;
        lsu_req_rd = e.rd;
        do @(posedge clk); while (!lsu_req_ready);
        @(negedge clk);
        lsu_req_valid = 1'b0;
    endtask

    task automatic send_random(int region, logic loads_only);
        lsu_op_t op;
        logic [1:0] off;
        op = loads_only ? lsu_op_t'(3'($urandom % 5)) : lsu_op_t'(3'($urandom % 8));
        case (op)
            LB, LBU, SB: off = 2'($urandom);
            LH, LHU, SH: off = {1'($urandom), 1'b0};
            default: off = 2'b00;
        endcase
        send(op, tmask_t'($urandom % 15 + 1), region, off);
    endtask

    // random stalls on the commit ports in the later tests
    initial begin
        ld_commit_ready = 1'b1;
        st_commit_ready = 1'b1;
        forever begin
            @(negedge clk);
            ld_commit_ready = !rand_bp || (($urandom % 3) != 0);
            st_commit_ready = !rand_bp || (($urandom % 4) != 0);
        end
    end

    initial begin
        exp_t e;
        forever begin
            @(posedge clk);
            // every effective address lies inside the model's memory
            for (int i = 0; i < NT; i++) begin
                if (dcache_req_valid[i] && dcache_req_ready[i]) begin
                    check_value(test_name, $sformatf("req addr lane %0d high bits", i), 32'(0),
                                32'(dcache_req_addr[i]) >> $clog2(MEM_WORDS));
                end
            end
            if (st_commit_valid && st_commit_ready) begin
                n_st++;
                if (st_q.size() == 0) begin
                    errors++;
                    $display("store commit with no store outstanding, pc %h", st_commit_pc);
                end else begin
                    e = st_q.pop_front();
                    check_value(e.name, "st wid", 32'(e.wid), 32'(st_commit_wid));
                    check_value(e.name, "st pc", e.pc, st_commit_pc);
                    check_value(e.name, "st tmask", 32'(e.tmask), 32'(st_commit_tmask));
                end
            end
            if (ld_commit_valid && ld_commit_ready) begin
                n_ld++;
                if (!ld_exp.exists(ld_commit_pc)) begin
                    errors++;
                    $display("load commit for a pc with no load outstanding, pc %h", ld_commit_pc);
                end else begin
                    e = ld_exp[ld_commit_pc];
                    check_value(e.name, "ld wid", 32'(e.wid), 32'(ld_commit_wid));
                    check_value(e.name, "ld rd", 32'(e.rd), 32'(ld_commit_rd));
                    // lanes outside the still-missing set
                    check_value(e.name, "ld stray lanes", 32'(0),
                                32'(ld_commit_tmask & ~(e.tmask & ~e.got)));
                    for (int i = 0; i < NT; i++) begin
                        if (ld_commit_tmask[i]) begin
                            check_value(e.name, $sformatf("ld data lane %0d", i), e.data[i],
                                        ld_commit_data[i]);
                        end
                    end
                    e.got = e.got | ld_commit_tmask;
                    check_value(e.name, "ld eop", 32'(e.got == e.tmask), 32'(ld_commit_eop));
                    if (ld_commit_eop || e.got == e.tmask) begin
                        ld_exp.delete(ld_commit_pc);
                    end else begin
                        ld_exp[ld_commit_pc] = e;
                    end
                end
            end
        end
    end

    initial begin
        repeat (NUM_TESTS * 200) @(posedge clk);
        $display("timeout, commits still outstanding after %0d cycles", NUM_TESTS * 200);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        void'($urandom(4296));
        next_pc = 32'h0000_1000;
        lsu_req_valid = 1'b0;
        lsu_req_wid = '0;
        lsu_req_tmask = '0;
        lsu_req_pc = '0;
        lsu_req_op = LW;
        lsu_req_base_addr = '0;
        lsu_req_offset = '0;
        lsu_req_store_data = '0;
        lsu_req_rd = '0;
        reset = 1'b1;
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            ref_mem[i] = cache.mem[i];
        end

        test_name = "sw_lw";
        send(SW, '1, 3, 2'd0);
        send(LW, '1, 3, 2'd0);

        test_name = "sub_word_store";
        for (int k = 0; k < 4; k++) begin
            send(SB, '1, 8 + k, 2'(k));
            send(LW, '1, 8 + k, 2'd0);
        end
        for (int k = 0; k < 2; k++) begin
            send(SH, '1, 12 + k, 2'(2 * k));
            send(LW, '1, 12 + k, 2'd0);
        end

        test_name = "sub_word_load";
        for (int k = 0; k < 4; k++) begin
            send(LB, '1, 16 + k, 2'(k));
            send(LBU, '1, 16 + k, 2'(k));
        end
        for (int k = 0; k < 2; k++) begin
            send(LH, '1, 20 + k, 2'(2 * k));
            send(LHU, '1, 20 + k, 2'(2 * k));
        end

        // small region so loads see earlier partial stores
        test_name = "partial_mask";
        rand_bp = 1'b1;
        for (int k = 0; k < 20; k++) begin
            send_random(24 + int'($urandom % 8), 1'b0);
        end

        test_name = "load_burst";
        for (int k = 0; k < 12; k++) begin
            send_random(32 + k, 1'b1);
        end

        while (st_q.size() != 0 || ld_exp.num() != 0) begin
            @(posedge clk);
        end
        // catch late duplicate commits
        repeat (50) @(posedge clk);
        $display("store commits %0d, load commits %0d, errors %0d", n_st, n_ld, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+design
design/lsu_pkg.sv
design/lsu_addr_stage.sv
design/lsu_req_issue.sv
design/lsu_tag_buffer.sv
design/lsu_rsp_format.sv
design/lsu_unit.sv
tests/dcache_model.sv
tests/lsu_tb.sv

// ==== Makefile ====
TOP = lsu_tb

all: run

build:
	verilator --binary --timing -j 0 --top-module $(TOP) -f src.f

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^TESTS PASSED$$" sim.log

lint:
	verilator --lint-only --top-module lsu_unit -f src.f

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean
